// File: icache_pkg.sv
package icache_pkg;

	// fetch address width
	localparam int ADDR_W = 32;

	// cache geometry
	localparam int NUM_WAYS = 4;
	localparam int NUM_SETS = 16;
	localparam int TAG_W = 22;

	// refill burst shape, eight 64-bit beats per 64-byte line
	localparam int LINE_BEATS = 8;
	localparam int BEAT_W = 64;

	// each sram word holds two beats
	localparam int BANK_W = 128;
	// entry address is {set index, offset[5:4]}
	localparam int SRAM_DEPTH = 64;

	// backing memory size in beats
	localparam int MEM_WORDS = 32;

	// instruction width returned to the core
	localparam int INST_W = 32;

	// derived field widths
	localparam int INDEX_W = $clog2(NUM_SETS);
	localparam int OFFSET_W = $clog2(LINE_BEATS * BEAT_W / 8);
	localparam int BEAT_CNT_W = $clog2(LINE_BEATS);
	localparam int SRAM_AW = $clog2(SRAM_DEPTH);
	localparam int MEM_AW = $clog2(MEM_WORDS);
	localparam int BEAT_OFF_W = $clog2(BEAT_W / 8);
	localparam int WORD_SEL_W = $clog2(BANK_W / INST_W);
	localparam int BYTE_SEL_W = $clog2(INST_W / 8);

	// refill controller states
	typedef enum logic {
		ST_IDLE,
		ST_REFILL
	} refill_state_t;

endpackage

// File: icache_data_sram.sv
`timescale 1ns/1ps

module icache_data_sram (
	input  logic                              clk,
	input  logic                              en,
	input  logic                              we,
	input  logic                              half_sel,
	input  logic [icache_pkg::SRAM_AW-1:0]    sram_addr,
	input  logic [icache_pkg::BEAT_W-1:0]     wdata,
	output logic [icache_pkg::BANK_W-1:0]     rdata
);
	import icache_pkg::*;

	// one way of line data, two beats per entry
	logic [BANK_W-1:0] mem [SRAM_DEPTH];

	// half-entry writes, one beat at a time
	always_ff @(posedge clk) begin
		if (en && we) begin
			if (half_sel) begin
				mem[sram_addr][BANK_W-1:BEAT_W] <= wdata;
			end else begin
				mem[sram_addr][BEAT_W-1:0] <= wdata;
			end
		end
	end

	// synchronous read
	// output holds its last value while the port is idle
	always_ff @(posedge clk) begin
		if (en && !we) begin
			rdata <= mem[sram_addr];
		end
	end

endmodule

// File: icache_tag_array.sv
`timescale 1ns/1ps

module icache_tag_array (
	input  logic                              clk,
	input  logic                              rst,
	input  logic [icache_pkg::ADDR_W-1:0]     lookup_addr,
	output logic [icache_pkg::NUM_WAYS-1:0]   way_hit,
	input  logic                              fill_en,
	input  logic [icache_pkg::NUM_WAYS-1:0]   fill_way,
	input  logic [icache_pkg::ADDR_W-1:0]     fill_addr,
	input  logic                              inval_valid,
	input  logic [icache_pkg::ADDR_W-1:0]     inval_addr
);
	import icache_pkg::*;

	// per-way tag storage and valid bits
	logic [TAG_W-1:0] tag_mem [NUM_WAYS][NUM_SETS];
	logic [NUM_SETS-1:0] valid_q [NUM_WAYS];

	// address fields for the three users
	logic [INDEX_W-1:0] lookup_idx;
	logic [TAG_W-1:0] lookup_tag;
	logic [INDEX_W-1:0] fill_idx;
	logic [TAG_W-1:0] fill_tag;
	logic [INDEX_W-1:0] inval_idx;
	logic [TAG_W-1:0] inval_tag;

	// index sits just above the line offset
	// tag is the top of the address
	assign lookup_idx = lookup_addr[OFFSET_W +: INDEX_W];
	assign lookup_tag = lookup_addr[ADDR_W-1 -: TAG_W];
	assign fill_idx = fill_addr[OFFSET_W +: INDEX_W];
	assign fill_tag = fill_addr[ADDR_W-1 -: TAG_W];
	assign inval_idx = inval_addr[OFFSET_W +: INDEX_W];
	assign inval_tag = inval_addr[ADDR_W-1 -: TAG_W];

	// all four ways compared in parallel
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			way_hit[w] = valid_q[w][lookup_idx] && (tag_mem[w][lookup_idx] == lookup_tag);
		end
	end

	// valid bits
	// fill sets the victim way after its last beat
	// invalidate clears every way holding the store's tag
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				valid_q[w] <= '0;
			end
		end else begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (fill_en && fill_way[w]) begin
					valid_q[w][fill_idx] <= 1'b1;
				end
				// old tag is compared, so a line being filled this cycle is kept
				if (inval_valid && (tag_mem[w][inval_idx] == inval_tag)) begin
					valid_q[w][inval_idx] <= 1'b0;
				end
			end
		end
	end

	// tags only change on a fill
	always_ff @(posedge clk) begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (fill_en && fill_way[w]) begin
				tag_mem[w][fill_idx] <= fill_tag;
			end
		end
	end

endmodule

// File: icache_refill_ctrl.sv
`timescale 1ns/1ps

module icache_refill_ctrl (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              miss,
	input  logic                              arready,
	input  logic                              rvalid,
	input  logic                              rlast,
	input  logic [icache_pkg::ADDR_W-1:0]     lookup_addr,
	output logic                              arvalid,
	output logic [icache_pkg::ADDR_W-1:0]     araddr,
	output logic                              refill_active,
	output logic [icache_pkg::ADDR_W-1:0]     fill_addr,
	output logic [icache_pkg::BEAT_CNT_W-1:0] beat_cnt,
	output logic [icache_pkg::NUM_WAYS-1:0]   victim_way
);
	import icache_pkg::*;

	refill_state_t state;
	refill_state_t state_nxt;

	logic ar_fire;

	// request a burst straight from the lookup miss
	// held by the core until the memory takes it
	assign arvalid = (state == ST_IDLE) && miss;
	assign araddr = {lookup_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
	assign ar_fire = arvalid && arready;
	assign refill_active = (state == ST_REFILL);

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (ar_fire) begin
					state_nxt = ST_REFILL;
				end
			end
			ST_REFILL: begin
				// back to lookup after the eighth beat
				if (rvalid && rlast) begin
					state_nxt = ST_IDLE;
				end
			end
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			beat_cnt <= '0;
			victim_way <= {{(NUM_WAYS-1){1'b0}}, 1'b1};
		end else begin
			state <= state_nxt;
			if (state == ST_IDLE) begin
				beat_cnt <= '0;
				// pseudo-random victim, one rotation per idle cycle
				victim_way <= {victim_way[NUM_WAYS-2:0], victim_way[NUM_WAYS-1]};
			end else if (rvalid) begin
				beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

	// line address for the sram writes and the tag fill
	always_ff @(posedge clk) begin
		if (ar_fire) begin
			fill_addr <= araddr;
		end
	end

endmodule

// File: icache.sv
`timescale 1ns/1ps

module icache (
	input  logic                              clk,
	input  logic                              rst,
	// core side
	input  logic                              valid,
	input  logic [icache_pkg::ADDR_W-1:0]     addr,
	input  logic                              flush,
	input  logic                              inval_valid,
	input  logic [icache_pkg::ADDR_W-1:0]     inval_addr,
	output logic [icache_pkg::INST_W-1:0]     inst,
	output logic                              ready,
	output logic                              hit,
	// memory side
	output logic [icache_pkg::ADDR_W-1:0]     araddr,
	output logic                              arvalid,
	input  logic                              arready,
	input  logic [icache_pkg::BEAT_W-1:0]     rdata,
	input  logic                              rvalid,
	input  logic                              rlast
);
	import icache_pkg::*;

	logic [NUM_WAYS-1:0] way_hit;
	logic hit_any;
	logic lookup_hit;
	logic refill_active;
	logic [ADDR_W-1:0] fill_addr;
	logic [BEAT_CNT_W-1:0] beat_cnt;
	logic [NUM_WAYS-1:0] victim_way;
	logic [SRAM_AW-1:0] sram_addr;
	logic [BANK_W-1:0] bank_rdata [NUM_WAYS];
	logic [BANK_W-1:0] bank_sel;
	logic [NUM_WAYS-1:0] sel_way_q;
	logic [WORD_SEL_W-1:0] word_sel_q;

	icache_tag_array u_tags (
		.clk(clk),
		.rst(rst),
		.lookup_addr(addr),
		.way_hit(way_hit),
		.fill_en(refill_active && rvalid && rlast),
		.fill_way(victim_way),
		.fill_addr(fill_addr),
		.inval_valid(inval_valid),
		.inval_addr(inval_addr)
	);

	icache_refill_ctrl u_refill (
		.clk(clk),
		.rst(rst),
		.miss(valid && !hit_any),
		.arready(arready),
		.rvalid(rvalid),
		.rlast(rlast),
		.lookup_addr(addr),
		.arvalid(arvalid),
		.araddr(araddr),
		.refill_active(refill_active),
		.fill_addr(fill_addr),
		.beat_cnt(beat_cnt),
		.victim_way(victim_way)
	);

	// hits only count while no refill is running
	assign hit_any = |way_hit;
	assign hit = !refill_active && hit_any;
	assign lookup_hit = valid && hit;

	// lookup reads {index, offset[5:4]}
	// refill writes {index, beat[2:1]}, beat[0] picks the half
	assign sram_addr = refill_active ?
		{fill_addr[OFFSET_W +: INDEX_W], beat_cnt[BEAT_CNT_W-1:1]} :
		{addr[OFFSET_W +: INDEX_W], addr[OFFSET_W-1:BEAT_OFF_W+1]};

	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		icache_data_sram u_data (
			.clk(clk),
			.en(refill_active ? (rvalid && victim_way[w]) : (valid && way_hit[w])),
			.we(refill_active),
			.half_sel(beat_cnt[0]),
			.sram_addr(sram_addr),
			.wdata(rdata),
			.rdata(bank_rdata[w])
		);
	end

	// ready one cycle after a hit
	// flush drops a pending response
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			ready <= 1'b0;
		end else begin
			ready <= lookup_hit;
		end
	end

	// remember which way was read for the output mux
	always_ff @(posedge clk) begin
		if (rst) begin
			sel_way_q <= '0;
		end else if (lookup_hit) begin
			sel_way_q <= way_hit;
		end
	end

	// word offset of the fetch, aligned with the sram output
	always_ff @(posedge clk) begin
		if (lookup_hit) begin
			word_sel_q <= addr[BYTE_SEL_W +: WORD_SEL_W];
		end
	end

	// at most one way is selected, so an OR is enough
	always_comb begin
		bank_sel = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (sel_way_q[w]) begin
				bank_sel = bank_sel | bank_rdata[w];
			end
		end
	end

	assign inst = bank_sel[word_sel_q * INST_W +: INST_W];

endmodule

// File: burst_mem.sv
`timescale 1ns/1ps

module burst_mem (
	input  logic                              clk,
	input  logic                              rst,
	input  logic [icache_pkg::ADDR_W-1:0]     araddr,
	input  logic                              arvalid,
	output logic                              arready,
	output logic [icache_pkg::BEAT_W-1:0]     rdata,
	output logic                              rvalid,
	output logic                              rlast
);
	import icache_pkg::*;

	// small program image, aliased over the whole address space
	logic [BEAT_W-1:0] mem [MEM_WORDS];

	logic busy;
	logic [MEM_AW-1:0] word_idx;
	logic [BEAT_CNT_W-1:0] beat_idx;

	initial begin
		$readmemh("prog.hex", mem);
	end

	// one burst at a time
	assign arready = !busy;

	// beats come straight from the array while busy
	assign rvalid = busy;
	assign rdata = mem[word_idx];
	assign rlast = busy && (beat_idx == BEAT_CNT_W'(LINE_BEATS - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			beat_idx <= '0;
		end else if (!busy) begin
			if (arvalid) begin
				busy <= 1'b1;
				beat_idx <= '0;
			end
		end else begin
			beat_idx <= beat_idx + 1'b1;
			if (rlast) begin
				busy <= 1'b0;
			end
		end
	end

	// start at the line's word, modulo the memory size
	// index wraps on its own
	always_ff @(posedge clk) begin
		if (!busy) begin
			word_idx <= araddr[BEAT_OFF_W +: MEM_AW];
		end else begin
			word_idx <= word_idx + 1'b1;
		end
	end

endmodule

// File: icache_subsystem.sv
`timescale 1ns/1ps

module icache_subsystem (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              valid,
	input  logic [icache_pkg::ADDR_W-1:0]     addr,
	input  logic                              flush,
	input  logic                              inval_valid,
	input  logic [icache_pkg::ADDR_W-1:0]     inval_addr,
	output logic [icache_pkg::INST_W-1:0]     inst,
	output logic                              ready,
	output logic                              hit
);
	import icache_pkg::*;

	// refill channel between cache and memory
	logic [ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [BEAT_W-1:0] rdata;
	logic rvalid;
	logic rlast;

	icache u_icache (
		.clk(clk),
		.rst(rst),
		.valid(valid),
		.addr(addr),
		.flush(flush),
		.inval_valid(inval_valid),
		.inval_addr(inval_addr),
		.inst(inst),
		.ready(ready),
		.hit(hit),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rvalid(rvalid),
		.rlast(rlast)
	);

	burst_mem u_mem (
		.clk(clk),
		.rst(rst),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rvalid(rvalid),
		.rlast(rlast)
	);

endmodule

// File: tb_icache.sv
`timescale 1ns/1ps

module tb_icache;
	import icache_pkg::*;

	typedef enum int {
		OP_FETCH,
		OP_PROBE,
		OP_PROBE_CNT,
		OP_CNT_CHECK,
		OP_INVAL,
		OP_FLUSH
	} tb_op_t;

	localparam int MAX_ENTRIES = 128;
	// exp value 2 means the hit flag is not checked
	localparam int DONT_CARE = 2;
	localparam int WORDS_PER_LINE = (SRAM_DEPTH / NUM_SETS) * (BANK_W / 32);
	localparam int LINE_BYTES = LINE_BEATS * BEAT_W / 8;
	localparam int SET_W = $clog2(NUM_SETS);

	logic clk;
	logic rst;
	logic valid;
	logic [ADDR_W-1:0] addr;
	logic flush;
	logic inval_valid;
	logic [ADDR_W-1:0] inval_addr;
	logic [31:0] inst;
	logic ready;
	logic hit;

	// stimulus table
	tb_op_t op_tab [MAX_ENTRIES];
	logic [ADDR_W-1:0] addr_tab [MAX_ENTRIES];
	int exp_tab [MAX_ENTRIES];
	int n_entries;

	// reference image and per-set model of the random window
	logic [BEAT_W-1:0] ref_mem [MEM_WORDS];
	logic [TAG_W-1:0] seen_tag [NUM_SETS][NUM_WAYS];
	int seen_cnt [NUM_SETS];
	logic [TAG_W-1:0] last_fill [NUM_SETS];

	int errors;
	int checks;
	int hit_count;
	int cycles;
	int cycle_limit = 100000;

	icache_subsystem uut (
		.clk(clk),
		.rst(rst),
		.valid(valid),
		.addr(addr),
		.flush(flush),
		.inval_valid(inval_valid),
		.inval_addr(inval_addr),
		.inst(inst),
		.ready(ready),
		.hit(hit)
	);

	always #4 clk = ~clk;

	// run limit, sized once the table is built
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("TB FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// word (addr[7:3] mod 32), upper half when addr[2] is set
	function automatic logic [31:0] ref_inst(input logic [ADDR_W-1:0] a);
		logic [BEAT_W-1:0] w;
		w = ref_mem[int'(a[7:3]) % MEM_WORDS];
		return a[2] ? w[63:32] : w[31:0];
	endfunction

	task automatic add_entry(input tb_op_t op, input logic [ADDR_W-1:0] a, input int e);
		op_tab[n_entries] = op;
		addr_tab[n_entries] = a;
		exp_tab[n_entries] = e;
		n_entries++;
	endtask

	// random window fetch, hit expected only where the answer is certain
	task automatic add_random_fetch(input logic [ADDR_W-1:0] a);
		int s;
		logic [TAG_W-1:0] t;
		int e;
		bit found;
		s = int'(a[6 +: SET_W]);
		t = a[ADDR_W-1 -: TAG_W];
		found = 0;
		for (int i = 0; i < seen_cnt[s]; i++) begin
			if (seen_tag[s][i] == t) begin
				found = 1;
			end
		end
		if (!found && seen_cnt[s] < NUM_WAYS) begin
			// new tag in this set, so a miss that fills it
			e = 0;
			seen_tag[s][seen_cnt[s]] = t;
			seen_cnt[s]++;
			last_fill[s] = t;
		end else if (found && last_fill[s] == t) begin
			e = 1;
		end else begin
			// another fill may have reused this way
			// hit or refill, this line is resident afterwards
			e = DONT_CARE;
			last_fill[s] = t;
		end
		add_entry(OP_FETCH, a, e);
	endtask

	task automatic check_hit(input logic [ADDR_W-1:0] a, input logic got, input int e);
		checks++;
		assert (int'(got) == e) else begin
			errors++;
			$display("ERROR: %0t hit flag for %h is %0d, expected %0d", $time, a, got, e);
		end
	endtask

	// core fetch held until ready
	task automatic fetch_word(input logic [ADDR_W-1:0] a, input int e);
		logic hit_seen;
		int lat;
		logic [31:0] want;
		want = ref_inst(a);
		@(posedge clk);
		valid <= 1'b1;
		addr <= a;
		@(negedge clk);
		hit_seen = hit;
		@(negedge clk);
		lat = 1;
		while (!ready) begin
			@(negedge clk);
			lat++;
		end
		checks++;
		assert (inst == want) else begin
			errors++;
			$display("ERROR: %0t fetch %h returned %h, expected %h", $time, a, inst, want);
		end
		if (e != DONT_CARE) begin
			check_hit(a, hit_seen, e);
		end
		if (e == 1) begin
			checks++;
			assert (lat == 1) else begin
				errors++;
				$display("ERROR: %0t hit on %h took %0d cycles", $time, a, lat);
			end
		end
		@(posedge clk);
		valid <= 1'b0;
		@(posedge clk);
	endtask

	// lookup with valid low, no refill started
	task automatic probe_hit(input logic [ADDR_W-1:0] a, output logic h);
		@(posedge clk);
		valid <= 1'b0;
		addr <= a;
		@(negedge clk);
		h = hit;
	endtask

	task automatic strobe_inval(input logic [ADDR_W-1:0] a);
		@(posedge clk);
		inval_valid <= 1'b1;
		inval_addr <= a;
		@(posedge clk);
		inval_valid <= 1'b0;
	endtask

	// hit request with flush in the same cycle
	task automatic flushed_fetch(input logic [ADDR_W-1:0] a);
		@(posedge clk);
		valid <= 1'b1;
		addr <= a;
		flush <= 1'b1;
		@(negedge clk);
		check_hit(a, hit, 1);
		@(posedge clk);
		valid <= 1'b0;
		flush <= 1'b0;
		@(negedge clk);
		checks++;
		assert (ready == 1'b0) else begin
			errors++;
			$display("ERROR: %0t ready high after flush on %h", $time, a);
		end
		@(posedge clk);
	endtask

	task automatic build_table();
		logic [31:0] rnd;
		n_entries = 0;
		// cold miss in set 2, then the same word as a hit
		add_entry(OP_FETCH, 32'h0002_0080, 0);
		add_entry(OP_FETCH, 32'h0002_0080, 1);
		// every word of that line
		for (int k = 0; k < WORDS_PER_LINE; k++) begin
			add_entry(OP_FETCH, 32'h0002_0080 + 4 * k, 1);
		end
		// four tags in set 5, back to back
		for (int k = 0; k < NUM_WAYS; k++) begin
			add_entry(OP_FETCH, ((32'h40 + k) << 10) | 32'h140, 0);
		end
		for (int k = 0; k < NUM_WAYS; k++) begin
			add_entry(OP_PROBE, ((32'h40 + k) << 10) | 32'h140, 1);
		end
		// fifth tag evicts exactly one of them
		add_entry(OP_FETCH, (32'h44 << 10) | 32'h140, 0);
		add_entry(OP_PROBE, (32'h44 << 10) | 32'h140, 1);
		for (int k = 0; k < NUM_WAYS; k++) begin
			add_entry(OP_PROBE_CNT, ((32'h40 + k) << 10) | 32'h140, DONT_CARE);
		end
		add_entry(OP_CNT_CHECK, NUM_WAYS - 1, DONT_CARE);
		// invalidation in set 7
		add_entry(OP_FETCH, 32'h0003_01C0, 0);
		add_entry(OP_FETCH, 32'h0003_41C0, 0);
		add_entry(OP_INVAL, 32'h0003_81C0, DONT_CARE);
		add_entry(OP_PROBE, 32'h0003_01C0, 1);
		add_entry(OP_PROBE, 32'h0003_41C0, 1);
		add_entry(OP_INVAL, 32'h0003_01C4, DONT_CARE);
		add_entry(OP_PROBE, 32'h0003_01C0, 0);
		add_entry(OP_PROBE, 32'h0003_41C0, 1);
		// flush on a hit, then a normal hit
		add_entry(OP_FLUSH, 32'h0002_0084, 1);
		add_entry(OP_FETCH, 32'h0002_0084, 1);
		// random stream over a 2 KiB window at address 0
		rnd = 32'd27016;
		for (int i = 0; i < 40; i++) begin
			rnd = next_random(rnd);
			add_random_fetch(rnd & (32'(2 * 1024 - 1) & ~32'h3));
		end
	endtask

	initial begin
		logic h;
		clk = 1'b0;
		rst = 1'b1;
		valid = 1'b0;
		addr = '0;
		flush = 1'b0;
		inval_valid = 1'b0;
		inval_addr = '0;
		errors = 0;
		checks = 0;
		hit_count = 0;
		cycles = 0;
		for (int s = 0; s < NUM_SETS; s++) begin
			seen_cnt[s] = 0;
			last_fill[s] = '0;
		end
		$readmemh("prog.hex", ref_mem);
		build_table();
		cycle_limit = n_entries * 20 + 100;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < n_entries; i++) begin
			case (op_tab[i])
				OP_FETCH: fetch_word(addr_tab[i], exp_tab[i]);
				OP_PROBE: begin
					probe_hit(addr_tab[i], h);
					check_hit(addr_tab[i], h, exp_tab[i]);
				end
				OP_PROBE_CNT: begin
					probe_hit(addr_tab[i], h);
					hit_count += int'(h);
				end
				OP_CNT_CHECK: begin
					checks++;
					assert (hit_count == int'(addr_tab[i])) else begin
						errors++;
						$display("ERROR: %0t %0d old tags still hit, expected %0d",
							$time, hit_count, addr_tab[i]);
					end
					hit_count = 0;
				end
				OP_INVAL: strobe_inval(addr_tab[i]);
				OP_FLUSH: flushed_fetch(addr_tab[i]);
				default: ;
			endcase
		end
		$display("checks: %0d  errors: %0d  line size: %0d bytes", checks, errors, LINE_BYTES);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: prog.hex
// one 64-bit word per line, word 0 first
// upper half c0de00NN, lower half NN00beef, NN is the word index
c0de00000000beef
c0de00010100beef
c0de00020200beef
c0de00030300beef
c0de00040400beef
c0de00050500beef
c0de00060600beef
c0de00070700beef
c0de00080800beef
c0de00090900beef
c0de000a0a00beef
c0de000b0b00beef
c0de000c0c00beef
c0de000d0d00beef
c0de000e0e00beef
c0de000f0f00beef
c0de00101000beef
c0de00111100beef
c0de00121200beef
c0de00131300beef
c0de00141400beef
c0de00151500beef
c0de00161600beef
c0de00171700beef
c0de00181800beef
c0de00191900beef
c0de001a1a00beef
c0de001b1b00beef
c0de001c1c00beef
c0de001d1d00beef
c0de001e1e00beef
c0de001f1f00beef

// File: vlog.f
icache_pkg.sv
icache_data_sram.sv
icache_tag_array.sv
icache_refill_ctrl.sv
icache.sv
burst_mem.sv
icache_subsystem.sv
tb_icache.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_icache -f vlog.f -o sim_icache
./obj_dir/sim_icache > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
	exit 1
fi
exit 0
